// File: Makefile
# Verilator flow for the vector store engine

.PHONY: all build lint clean

all: build
	./obj_dir/Vvstore_tb | tee sim.log
	@! grep -q "SOME TESTS FAILED" sim.log
	@grep -q "ALL TESTS PASSED" sim.log

build:
	verilator --binary --timing --assert --top-module vstore_tb -Mdir obj_dir -f all.f

lint:
	verilator --lint-only -Wall --top-module vstore_unit \
		logic/vstore_pkg.sv logic/vstore_seq.sv logic/vstore_req_gen.sv logic/vstore_unit.sv

clean:
	rm -rf obj_dir sim.log

// File: all.f
logic/vstore_pkg.sv
logic/vstore_seq.sv
logic/vstore_req_gen.sv
logic/vstore_unit.sv
tests/vstore_properties.sv
tests/vstore_tb.sv

// File: logic/vstore_pkg.sv
//==========================================================================
// Vector store engine shared definitions
// Widths, element and register types, modes, FSM states, instruction format
//==========================================================================
package vstore_pkg;

    //======================================================================
    // Widths
    //======================================================================
    localparam int ADDR_W    = 32;                  // Byte address
    localparam int DATA_W    = 32;                  // One element
    localparam int NUM_VREGS = 32;                  // Architectural vector registers
    localparam int MAX_VL_W  = 9;                   // Up to 32 regs x 8 lanes
    localparam int MAX_LANES = 8;                   // Widest lane configuration
    localparam int LANE_W    = $clog2(MAX_LANES);   // Lane pointer width

    //======================================================================
    // Plain vector types
    //======================================================================
    typedef logic [ADDR_W-1:0]             addr_t;  // Byte address
    typedef logic [DATA_W-1:0]             data_t;  // Store element
    typedef logic [$clog2(NUM_VREGS)-1:0]  vreg_t;  // Register number
    typedef logic [MAX_VL_W-1:0]           vl_t;    // Length in elements
    typedef logic [LANE_W-1:0]             lane_t;  // Lane inside one register

    // Addressing mode of a store
    typedef enum logic [1:0] {
        MEM_UNIT_STRIDED = 2'd0,  // Consecutive words
        MEM_INDEXED      = 2'd1,  // Base plus per-element offset
        MEM_STRIDED      = 2'd2   // Base plus i times stride
    } mem_op_e;

    // Sequencer FSM
    typedef enum logic [1:0] {
        SEQ_IDLE      = 2'd0,  // Waiting for an instruction
        SEQ_ISSUE     = 2'd1,  // Issuing element requests of one pass
        SEQ_NEXT_PASS = 2'd2   // Unlock and step to the next register
    } seq_state_e;

    // Store instruction as handed over by the issue stage
    typedef struct packed {
        mem_op_e mem_op;     // Addressing mode
        addr_t   base_addr;  // First byte address
        addr_t   stride;     // Byte stride, strided mode only
        vl_t     vl;         // Element count, never zero
        vreg_t   data_vreg;  // First register holding store data
        vreg_t   idx_vreg;   // First register holding index offsets
    } vstore_instr_t;

    // Current element position, sequencer to request generator
    typedef struct packed {
        lane_t lane;       // Lane pointer in the current pass
        vreg_t data_vreg;  // Data register of this pass
        vreg_t idx_vreg;   // Index register of this pass
    } elem_pos_t;

endpackage

// File: logic/vstore_req_gen.sv
//==========================================================================
// Vector store request generator
// Builds element address and data, tracks the touched address range
//==========================================================================
`timescale 1ns/1ps

module vstore_req_gen import vstore_pkg::*; #(
    parameter int VLANES = 8
) (
    input  logic                     clk,
    input  logic                     rst_n,
    // Control from the sequencer
    input  logic                     accept_i,   // Capture instruction fields
    input  logic                     advance_i,  // Step to the next element
    input  vstore_instr_t            instr_i,
    input  elem_pos_t                pos_i,
    // Register file read data, lane packed
    input  logic [VLANES*DATA_W-1:0] rd_data_i,
    input  logic [VLANES*DATA_W-1:0] rd_idx_i,
    // Request payload
    output addr_t                    req_addr_o,
    output data_t                    req_data_o,
    // Address range for hazard checks
    output addr_t                    start_addr_o,
    output addr_t                    end_addr_o
);

    //======================================================================
    // Captured instruction state
    //======================================================================
    mem_op_e mode_r;
    addr_t   base_r;
    addr_t   stride_r;
    addr_t   addr_r;      // Running address, strided modes
    addr_t   start_r;
    addr_t   end_r;

    addr_t   step;        // Address increment per element
    addr_t   offset;      // Index lane at the pointer
    addr_t   vl_m1;       // vl - 1 widened to an address
    addr_t   end_nxt;

    // Lane select at the element pointer
    assign offset     = addr_t'(rd_idx_i[pos_i.lane*DATA_W +: DATA_W]);
    assign req_data_o = rd_data_i[pos_i.lane*DATA_W +: DATA_W];

    // Indexed uses the live offset, the others the running address
    assign req_addr_o = (mode_r == MEM_INDEXED) ? base_r + offset : addr_r;

    always_comb begin
        case (mode_r)
            MEM_UNIT_STRIDED: step = addr_t'(4);  // One word
            MEM_STRIDED:      step = stride_r;
            default:          step = '0;          // Indexed has no running address
        endcase
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (accept_i) begin
            base_r   <= instr_i.base_addr;
            stride_r <= instr_i.stride;
            addr_r   <= instr_i.base_addr;
        end else if (advance_i) begin
            addr_r <= addr_r + step;  // Held under back-pressure
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_r <= MEM_UNIT_STRIDED;
        end else if (accept_i) begin
            mode_r <= instr_i.mem_op;
        end
    end

    //======================================================================
    // Address range
    //======================================================================
    assign vl_m1 = addr_t'(instr_i.vl - vl_t'(1));

    always_comb begin
        case (instr_i.mem_op)
            MEM_UNIT_STRIDED: end_nxt = instr_i.base_addr + (vl_m1 << 2);
            MEM_STRIDED:      end_nxt = instr_i.base_addr + vl_m1 * instr_i.stride;
            default:          end_nxt = instr_i.base_addr;  // Offsets unknown upfront
        endcase
    end

    // Range holds until the next instruction is taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_r <= '0;
            end_r   <= '1;  // Widest range out of reset
        end else if (accept_i) begin
            start_r <= instr_i.base_addr;
            end_r   <= end_nxt;
        end
    end

    assign start_addr_o = start_r;
    assign end_addr_o   = end_r;

endmodule

// File: logic/vstore_seq.sv
//==========================================================================
// Vector store sequencer
// Walks elements lane by lane and register by register, owns the handshakes
//==========================================================================
`timescale 1ns/1ps

module vstore_seq import vstore_pkg::*; #(
    parameter int VLANES = 8
) (
    input  logic          clk,
    input  logic          rst_n,
    // Instruction handshake
    input  logic          instr_valid_i,
    input  vstore_instr_t instr_i,
    output logic          instr_ready_o,
    // Memory request handshake
    input  logic          req_ready_i,
    output logic          req_valid_o,
    // Towards the request generator
    output logic          accept_o,       // Instruction taken this cycle
    output logic          advance_o,      // Request completed this cycle
    output elem_pos_t     pos_o,
    // Hazard sync
    output logic          unlock_valid_o,
    output vreg_t         unlock_vreg_o,
    output logic          busy_o
);

    localparam int CNT_W = MAX_VL_W + 1;  // Headroom for pass end counts

    //======================================================================
    // State
    //======================================================================
    seq_state_e         state_r;
    seq_state_e         state_nxt;
    logic [VLANES-1:0]  pending_r;     // Elements still to send in this pass
    lane_t              ptr_r;         // Lane of the element on the bus
    vl_t                pass_cnt_r;    // Passes finished so far
    vl_t                vl_r;          // Length of the running instruction
    vreg_t              data_vreg_r;
    vreg_t              idx_vreg_r;

    logic [VLANES-1:0]  lane_oh;
    logic [VLANES-1:0]  pend_clr;
    logic [CNT_W-1:0]   done_cnt;      // Elements covered up to this pass
    logic [CNT_W-1:0]   remain_cnt;    // Elements for later passes
    logic               last_pass;
    logic               pass_done;
    logic               finish;

    // Pending mask for a pass of min(n, VLANES) elements
    function automatic logic [VLANES-1:0] pass_mask(input logic [CNT_W-1:0] n);
        logic [VLANES-1:0] mask;
        if (n >= CNT_W'(VLANES)) begin
            mask = '1;
        end else begin
            mask = ~({VLANES{1'b1}} << n);
        end
        return mask;
    endfunction

    //======================================================================
    // Pass bookkeeping
    //======================================================================
    assign done_cnt   = (CNT_W'(pass_cnt_r) + CNT_W'(1)) * CNT_W'(VLANES);
    assign remain_cnt = CNT_W'(vl_r) - done_cnt;  // Only read when more passes follow
    assign last_pass  = (done_cnt >= CNT_W'(vl_r));

    assign lane_oh   = {{(VLANES-1){1'b0}}, 1'b1} << ptr_r;
    assign pend_clr  = pending_r & ~lane_oh;       // Mask once this lane is sent
    assign pass_done = (pend_clr == '0);           // Current lane is the last one
    assign finish    = advance_o & pass_done & last_pass;

    //======================================================================
    // Handshakes and sync outputs
    //======================================================================
    assign req_valid_o   = (state_r == SEQ_ISSUE);
    assign advance_o     = req_valid_o & req_ready_i;
    assign instr_ready_o = (state_r == SEQ_IDLE) | finish;  // Allows back to back
    assign accept_o      = instr_valid_i & instr_ready_o;

    assign unlock_valid_o = (state_r == SEQ_NEXT_PASS) | finish;
    assign unlock_vreg_o  = data_vreg_r;  // Still the register just drained
    assign busy_o         = (state_r != SEQ_IDLE);

    assign pos_o.lane      = ptr_r;
    assign pos_o.data_vreg = data_vreg_r;
    assign pos_o.idx_vreg  = idx_vreg_r;

    // Next state
    always_comb begin
        state_nxt = state_r;
        case (state_r)
            SEQ_IDLE: begin
                if (accept_o) state_nxt = SEQ_ISSUE;
            end
            SEQ_ISSUE: begin
                if (advance_o && pass_done) begin
                    if (!last_pass) begin
                        state_nxt = SEQ_NEXT_PASS;  // More registers to go
                    end else if (accept_o) begin
                        state_nxt = SEQ_ISSUE;      // Next instruction right away
                    end else begin
                        state_nxt = SEQ_IDLE;
                    end
                end
            end
            SEQ_NEXT_PASS: state_nxt = SEQ_ISSUE;   // Single bubble cycle
            default:       state_nxt = SEQ_IDLE;
        endcase
    end

    //======================================================================
    // Registers
    //======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_r     <= SEQ_IDLE;
            pending_r   <= '0;
            ptr_r       <= '0;
            pass_cnt_r  <= '0;
            vl_r        <= '0;
            data_vreg_r <= '0;
            idx_vreg_r  <= '0;
        end else begin
            state_r <= state_nxt;
            if (accept_o) begin
                // First pass of a new instruction
                pending_r   <= pass_mask(CNT_W'(instr_i.vl));
                ptr_r       <= '0;
                pass_cnt_r  <= '0;
                vl_r        <= instr_i.vl;
                data_vreg_r <= instr_i.data_vreg;
                idx_vreg_r  <= instr_i.idx_vreg;
            end else if (state_r == SEQ_NEXT_PASS) begin
                pending_r   <= pass_mask(remain_cnt);  // Reload for next register
                ptr_r       <= '0;
                pass_cnt_r  <= pass_cnt_r + vl_t'(1);
                data_vreg_r <= data_vreg_r + vreg_t'(1);
                idx_vreg_r  <= idx_vreg_r + vreg_t'(1);
            end else if (advance_o) begin
                pending_r <= pend_clr;
                ptr_r     <= ptr_r + lane_t'(1);
            end
        end
    end

endmodule

// File: logic/vstore_unit.sv
//==========================================================================
// Vector store engine top level
// Sequencer plus request generator, one 32-bit element per request
//==========================================================================
`timescale 1ns/1ps

module vstore_unit import vstore_pkg::*; #(
    parameter int VLANES = 8  // Lanes per vector register
) (
    input  logic                     clk,
    input  logic                     rst_n,
    // Instruction handshake
    input  logic                     instr_valid_i,
    input  vstore_instr_t            instr_i,
    output logic                     instr_ready_o,
    // Register file, read data returns in the same cycle
    output vreg_t                    rd_data_vreg_o,
    output vreg_t                    rd_idx_vreg_o,
    input  logic [VLANES*DATA_W-1:0] rd_data_i,
    input  logic [VLANES*DATA_W-1:0] rd_idx_i,
    // Memory request handshake
    output logic                     req_valid_o,
    input  logic                     req_ready_i,
    output addr_t                    req_addr_o,
    output data_t                    req_data_o,
    // Hazard sync
    output logic                     unlock_valid_o,
    output vreg_t                    unlock_vreg_o,
    output logic                     busy_o,
    output addr_t                    start_addr_o,
    output addr_t                    end_addr_o
);

    //======================================================================
    // Internal wiring
    //======================================================================
    logic      accept;   // Instruction taken
    logic      advance;  // Request completed
    elem_pos_t pos;      // Lane pointer and register numbers

    // Register numbers of the current pass drive the read ports
    assign rd_data_vreg_o = pos.data_vreg;
    assign rd_idx_vreg_o  = pos.idx_vreg;

    vstore_seq #(
        .VLANES         (VLANES)
    ) vstore_seq_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .instr_ready_o  (instr_ready_o),
        .req_ready_i    (req_ready_i),
        .req_valid_o    (req_valid_o),
        .accept_o       (accept),
        .advance_o      (advance),
        .pos_o          (pos),
        .unlock_valid_o (unlock_valid_o),
        .unlock_vreg_o  (unlock_vreg_o),
        .busy_o         (busy_o)
    );

    // Address and data path
    vstore_req_gen #(
        .VLANES       (VLANES)
    ) vstore_req_gen_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .accept_i     (accept),
        .advance_i    (advance),
        .instr_i      (instr_i),
        .pos_i        (pos),
        .rd_data_i    (rd_data_i),
        .rd_idx_i     (rd_idx_i),
        .req_addr_o   (req_addr_o),
        .req_data_o   (req_data_o),
        .start_addr_o (start_addr_o),
        .end_addr_o   (end_addr_o)
    );

endmodule

// File: tests/vstore_properties.sv
//==========================================================================
// Vector store engine properties
// Request handshake stability and sync output sanity, bound into the top
//==========================================================================
`timescale 1ns/1ps

module vstore_properties import vstore_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  req_valid_i,
    input logic  req_ready_i,
    input addr_t req_addr_i,
    input data_t req_data_i,
    input logic  busy_i,
    input logic  unlock_valid_i
);

    int unsigned fail_cnt = 0;  // Read by the testbench at the end of the run

    // A stalled request keeps its payload until taken
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid_i && !req_ready_i |=>
            req_valid_i && $stable(req_addr_i) && $stable(req_data_i))
    else begin
        $error("request valid, address or data changed under back-pressure");
        fail_cnt++;
    end

    a_valid_busy: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid_i |-> busy_i)
    else begin
        $error("request valid while the engine is not busy");
        fail_cnt++;
    end

    a_unlock_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !busy_i |-> !unlock_valid_i)
    else begin
        $error("unlock pulsed while the engine is idle");
        fail_cnt++;
    end

endmodule

bind vstore_unit vstore_properties vstore_properties_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid_i    (req_valid_o),
    .req_ready_i    (req_ready_i),
    .req_addr_i     (req_addr_o),
    .req_data_i     (req_data_o),
    .busy_i         (busy_o),
    .unlock_valid_i (unlock_valid_o)
);

// File: tests/vstore_tb.sv
//==========================================================================
// Vector store engine testbench
// Register file model, random back-pressure, reference model and checks
//==========================================================================
`timescale 1ns/1ps

module vstore_tb import vstore_pkg::*;;

    localparam int VLANES      = 8;
    localparam int CLK_PERIOD  = 40;
    localparam int TOTAL_ELEMS = 5 + 20 + 12 + 1 + 3 + 6 + 9;  // All tests together

    logic clk;
    logic rst_n;
    logic instr_valid_i;
    logic instr_ready_o;
    logic req_valid_o;
    logic req_ready_i;
    logic unlock_valid_o;
    logic busy_o;
    vstore_instr_t instr_i;
    vreg_t rd_data_vreg_o;
    vreg_t rd_idx_vreg_o;
    vreg_t unlock_vreg_o;
    addr_t req_addr_o;
    addr_t start_addr_o;
    addr_t end_addr_o;
    data_t req_data_o;
    logic [VLANES*DATA_W-1:0] rd_data_i;
    logic [VLANES*DATA_W-1:0] rd_idx_i;

    data_t         vregs [NUM_VREGS][VLANES];  // Register file model
    logic [31:0]   lfsr_q = 32'h18dd219e;
    vstore_instr_t instr_q[$];                 // Accepted, not yet drained
    vreg_t         unlock_log[$];
    int            elem_idx = 0;               // Next element of instr_q[0]
    int            done_cnt = 0;
    int            b2b_cnt  = 0;               // Accepts during a finishing request
    int            check_cnt = 0;
    int            err_cnt = 0;
    int            test_err_base = 0;
    int            tests_run = 0;
    int            tests_pass = 0;
    logic          first_due = 1'b0;
    addr_t         exp_start = '0;             // Range registers out of reset
    addr_t         exp_end_q = '1;

    vstore_unit #(.VLANES(VLANES)) vstore_unit_i (.*);

    //======================================================================
    // Clock, register file model, random ready
    //======================================================================
    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always_comb begin
        for (int l = 0; l < VLANES; l++) begin
            rd_data_i[l*DATA_W +: DATA_W] = vregs[rd_data_vreg_o][l];
            rd_idx_i[l*DATA_W +: DATA_W]  = vregs[rd_idx_vreg_o][l];
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};  // One step per bit
        end
    endtask

    task automatic fill_vregs();
        logic [31:0] w;
        for (int r = 0; r < NUM_VREGS; r++) begin
            for (int l = 0; l < VLANES; l++) begin
                draw_bits(32, w);
                vregs[r][l] = w;
            end
        end
    endtask

    always @(posedge clk) begin
        logic [31:0] b;
        #2;
        draw_bits(1, b);
        req_ready_i = b[0];  // Half the cycles stall
    end

    //======================================================================
    // Reference model and check helpers
    //======================================================================
    function automatic void exp_req(input vstore_instr_t ins, input int i,
                                    output addr_t a, output data_t d);
        int    pass;
        int    lane;
        vreg_t dreg;
        vreg_t ireg;
        pass = i / VLANES;
        lane = i % VLANES;
        dreg = ins.data_vreg + vreg_t'(pass);  // One register per pass
        ireg = ins.idx_vreg + vreg_t'(pass);
        d = vregs[dreg][lane];
        case (ins.mem_op)
            MEM_UNIT_STRIDED: a = ins.base_addr + addr_t'(i) * 32'd4;
            MEM_STRIDED:      a = ins.base_addr + addr_t'(i) * ins.stride;
            default:          a = ins.base_addr + vregs[ireg][lane];
        endcase
    endfunction

    function automatic addr_t exp_end(input vstore_instr_t ins);
        addr_t last;
        last = addr_t'(ins.vl) - 32'd1;
        case (ins.mem_op)
            MEM_UNIT_STRIDED: return ins.base_addr + last * 32'd4;
            MEM_STRIDED:      return ins.base_addr + last * ins.stride;
            default:          return ins.base_addr;  // Offsets unknown upfront
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_cnt++;
        assert (got === exp) else begin
            $display("error %0t ns: %s is %h, expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        check_cnt++;
        assert (cond) else begin
            $display("error %0t ns: %s", $time, what);
            err_cnt++;
        end
    endtask

    //======================================================================
    // Comparator, sampled mid-cycle where everything is settled
    //======================================================================
    always @(negedge clk) begin
        addr_t         a;
        data_t         d;
        vstore_instr_t cur;
        if (rst_n) begin
            check_value("start_addr_o", start_addr_o, exp_start);
            check_value("end_addr_o", end_addr_o, exp_end_q);
            if (first_due) begin
                check_true(req_valid_o, "no request in the cycle after acceptance");
                first_due = 1'b0;
            end
            if (unlock_valid_o) unlock_log.push_back(unlock_vreg_o);
            if (req_valid_o && req_ready_i) begin
                if (instr_q.size() == 0) begin
                    check_true(1'b0, "request completed with no instruction outstanding");
                end else begin
                    cur = instr_q[0];
                    exp_req(cur, elem_idx, a, d);
                    check_value("req_addr_o", req_addr_o, a);
                    check_value("req_data_o", req_data_o, d);
                    elem_idx++;
                    if (elem_idx == int'(cur.vl)) begin  // Instruction drained
                        instr_q.delete(0);
                        elem_idx = 0;
                        done_cnt++;
                    end
                end
            end
            // After the request, since a finishing request precedes the new one
            if (instr_valid_i && instr_ready_o) begin
                if (req_valid_o) b2b_cnt++;
                instr_q.push_back(instr_i);
                exp_start = instr_i.base_addr;
                exp_end_q = exp_end(instr_i);
                first_due = 1'b1;
            end
        end
    end

    //======================================================================
    // Stimulus
    //======================================================================
    function automatic vstore_instr_t make_instr(input mem_op_e op, input addr_t base,
                                                 input addr_t stride, input int vl,
                                                 input int dv, input int iv);
        vstore_instr_t ins;
        ins.mem_op    = op;
        ins.base_addr = base;
        ins.stride    = stride;
        ins.vl        = vl_t'(vl);
        ins.data_vreg = vreg_t'(dv);
        ins.idx_vreg  = vreg_t'(iv);
        return ins;
    endfunction

    // Entered and left 2 ns after a rising edge
    task automatic send_instr(input vstore_instr_t ins);
        instr_i       = ins;
        instr_valid_i = 1'b1;
        do @(negedge clk); while (!instr_ready_o);
        @(posedge clk);
        #2;
        instr_valid_i = 1'b0;
    endtask

    task automatic wait_done(input int n);
        wait (done_cnt == n);
        @(posedge clk);
        #2;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (err_cnt == test_err_base) begin
            tests_pass++;
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            $display("test %0d %s: fail, %0d errors", tests_run, name,
                     err_cnt - test_err_base);
        end
        test_err_base = err_cnt;
    endtask

    initial begin
        int b2b_base;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        req_ready_i   = 1'b0;
        rst_n         = 1'b0;
        fill_vregs();
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        check_value("busy_o", 32'(busy_o), 32'd0);
        check_value("req_valid_o", 32'(req_valid_o), 32'd0);
        check_value("unlock_valid_o", 32'(unlock_valid_o), 32'd0);
        check_value("instr_ready_o", 32'(instr_ready_o), 32'd1);
        check_value("start_addr_o", start_addr_o, 32'h0000_0000);
        check_value("end_addr_o", end_addr_o, 32'hffff_ffff);
        finish_test("reset state");

        send_instr(make_instr(MEM_UNIT_STRIDED, 32'h0000_1000, 32'd0, 5, 3, 0));
        wait_done(1);
        finish_test("unit-strided store");

        unlock_log.delete();
        send_instr(make_instr(MEM_STRIDED, 32'h0002_0040, 32'd12, 20, 4, 0));
        wait_done(2);
        check_value("busy_o", 32'(busy_o), 32'd0);
        check_value("instr_ready_o", 32'(instr_ready_o), 32'd1);
        finish_test("strided store over three passes");

        check_value("unlock pulse count", 32'(unlock_log.size()), 32'd3);
        for (int k = 0; k < unlock_log.size() && k < 3; k++) begin
            check_value("unlock_vreg_o", 32'(unlock_log[k]), 32'(4 + k));
        end
        finish_test("unlock sequence");

        send_instr(make_instr(MEM_INDEXED, 32'h8000_0000, 32'd0, 12, 10, 20));
        wait_done(3);
        finish_test("indexed store");

        // Range rule, single element and a negative stride
        send_instr(make_instr(MEM_UNIT_STRIDED, 32'h0000_3ffc, 32'd0, 1, 7, 0));
        wait_done(4);
        send_instr(make_instr(MEM_STRIDED, 32'h0001_0000, 32'hffff_fff0, 3, 8, 0));
        wait_done(5);
        check_value("end_addr_o", end_addr_o, 32'h0000_ffe0);
        finish_test("range outputs");

        b2b_base = b2b_cnt;
        send_instr(make_instr(MEM_UNIT_STRIDED, 32'h0000_0400, 32'd0, 6, 30, 0));
        send_instr(make_instr(MEM_INDEXED, 32'h0000_0100, 32'd0, 9, 31, 2));  // Wraps to v0
        wait_done(7);
        check_true(b2b_cnt == b2b_base + 1, "second instruction was not accepted back to back");
        finish_test("back-to-back instructions");

        err_cnt += int'(vstore_unit_i.vstore_properties_i.fail_cnt);
        $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_pass, tests_run - tests_pass, check_cnt, err_cnt);
        if (err_cnt == 0 && tests_pass == tests_run) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog, four cycles per element plus setup slack
    initial begin
        #(CLK_PERIOD * (TOTAL_ELEMS * 4 + 200));
        $display("watchdog expired, the engine stopped making progress");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule
